// ==== source/fix_proto_pkg.sv ====
// FIX protocol byte values, delimiter position code and the shared word union

`default_nettype none

package fix_proto_pkg;

	// Delimiter bytes
	localparam logic [7:0] FIX_SOH = 8'h01; // Field end
	localparam logic [7:0] FIX_SEP = 8'h3D; // '=' between tag and value

	localparam int unsigned FIX_WORD_BYTES = 4;

	// Byte position of a delimiter inside a word.
	// 0 is bits 7:0 and 3 is bits 31:24 which is first on the wire.
	typedef logic [2:0] fix_pos_t;

	localparam fix_pos_t FIX_POS_NONE = 3'b111; // No delimiter in the word

	// Same 32 bits seen per byte lane or as one word
	typedef union packed {
		logic [FIX_WORD_BYTES-1:0][7:0] bytes; // Lane compare in the detector
		logic [31:0]                    word;  // Slicing in the extractor
	} fix_word_u;

endpackage : fix_proto_pkg

`default_nettype wire

// ==== source/fix_parser_cfg_pkg.sv ====
// Word buffer depth and pointer width of the FIX parser

`default_nettype none

package fix_parser_cfg_pkg;

	localparam int unsigned FIFO_DEPTH = 4; // Words held during a stall
	localparam int unsigned FIFO_PTR_W = 2; // Pointers wrap at FIFO_DEPTH

endpackage : fix_parser_cfg_pkg

`default_nettype wire

// ==== source/fix_word_if.sv ====
// Word link between parser stages carrying data, SOH and '=' positions and valid

`timescale 1ns/1ps
`default_nettype none

interface fix_word_if;
	import fix_proto_pkg::*;

	fix_word_u word;
	fix_pos_t  soh_pos;  // Earliest SOH in stream order
	fix_pos_t  sep_pos;  // Earliest '=' in stream order
	logic      valid;

	modport src (
		output word,
		output soh_pos,
		output sep_pos,
		output valid
	);

	modport dst (
		input word,
		input soh_pos,
		input sep_pos,
		input valid
	);

endinterface : fix_word_if

`default_nettype wire

// ==== source/fix_delim_detector.sv ====
// Delimiter detector registering each input word with its SOH and '=' positions

`timescale 1ns/1ps
`default_nettype none

module fix_delim_detector (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  fix_proto_pkg::fix_word_u word_i,
	input  logic                     word_valid_i,
	fix_word_if.src                  out
);
	import fix_proto_pkg::*;

	fix_pos_t soh_pos;
	fix_pos_t sep_pos;

	// Higher lanes come first on the wire, so the last hit in the loop wins
	always_comb begin
		soh_pos = FIX_POS_NONE;
		sep_pos = FIX_POS_NONE;
		for (int i = 0; i < FIX_WORD_BYTES; i++) begin
			if (word_i.bytes[i] == FIX_SOH) begin
				soh_pos = fix_pos_t'(i);
			end
			if (word_i.bytes[i] == FIX_SEP) begin
				sep_pos = fix_pos_t'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			out.valid <= 1'b0;
		end else begin
			out.valid <= word_valid_i; // One cycle strobe per word
		end
	end

	always_ff @(posedge clk) begin
		if (word_valid_i) begin
			out.word    <= word_i;
			out.soh_pos <= soh_pos;
			out.sep_pos <= sep_pos;
		end
	end

	// Only lane indices or the none code may leave the detector
	a_pos_code_legal: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		out.valid |-> !(out.soh_pos inside {[3'd4:3'd6]}) &&
		              !(out.sep_pos inside {[3'd4:3'd6]})
	);

endmodule : fix_delim_detector

`default_nettype wire

// ==== source/fix_word_fifo.sv ====
// Circular word buffer between detector and extractor with sticky overflow flag

`timescale 1ns/1ps
`default_nettype none

module fix_word_fifo (
	input  logic    clk,
	input  logic    arst_n_i,
	fix_word_if.dst in,
	fix_word_if.src out,
	input  logic    pop_i,
	output logic    overflow_o
);
	import fix_proto_pkg::*;
	import fix_parser_cfg_pkg::*;

	fix_word_u             word_mem [FIFO_DEPTH];
	fix_pos_t              soh_mem  [FIFO_DEPTH];
	fix_pos_t              sep_mem  [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0]   count; // One bit wider to tell full from empty
	logic                  full;
	logic                  empty;
	logic                  wr_en;
	logic                  rd_en;

	assign full  = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign wr_en = in.valid && !full; // Full is checked before any pop
	assign rd_en = pop_i && !empty;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1; // Natural wrap
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Idle or write with pop
			endcase
			if (in.valid && full) begin
				overflow_o <= 1'b1; // Held until reset
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			word_mem[wr_ptr] <= in.word;
			soh_mem[wr_ptr]  <= in.soh_pos;
			sep_mem[wr_ptr]  <= in.sep_pos;
		end
	end

	// Head of the queue
	assign out.word    = word_mem[rd_ptr];
	assign out.soh_pos = soh_mem[rd_ptr];
	assign out.sep_pos = sep_mem[rd_ptr];
	assign out.valid   = !empty;

	a_no_pop_when_empty: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		pop_i |-> !empty
	);

	a_count_in_range: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		count <= (FIFO_PTR_W + 1)'(FIFO_DEPTH)
	);

endmodule : fix_word_fifo

`default_nettype wire

// ==== source/fix_field_extractor.sv ====
// Field extractor splitting words into tag and body fragments with continuation status

`timescale 1ns/1ps
`default_nettype none

module fix_field_extractor (
	input  logic        clk,
	input  logic        arst_n_i,
	fix_word_if.dst     in,
	input  logic        stall_i,
	output logic        pop_o,
	output logic [31:0] tag_o,
	output logic [31:0] body_o,
	output logic        tag_valid_o,
	output logic        body_valid_o,
	output logic        tag_status_o,
	output logic        body_status_o
);
	import fix_proto_pkg::*;

	logic [31:0] w;
	fix_pos_t    soh;
	fix_pos_t    sep;
	logic [31:0] tag_d;
	logic [31:0] body_d;
	logic        tag_vld_d;
	logic        body_vld_d;
	logic        tag_st_d;
	logic        body_st_d;

	assign w   = in.word.word;
	assign soh = in.soh_pos;
	assign sep = in.sep_pos;

	assign pop_o = in.valid && !stall_i;

	// Decode on the SOH / '=' pair, fragments right aligned
	always_comb begin
		tag_d      = '0;
		body_d     = '0;
		tag_vld_d  = 1'b0;
		body_vld_d = 1'b0;
		tag_st_d   = 1'b0;
		body_st_d  = 1'b0;
		if (soh != FIX_POS_NONE && sep != FIX_POS_NONE) begin
			case ({soh, sep})
				{3'd3, 3'd1}: begin // Short tag between SOH and '='
					tag_d     = 32'(w[23:16]);
					tag_vld_d = 1'b1;
					body_st_d = 1'b1;
				end
				{3'd3, 3'd0}: begin
					tag_d     = 32'(w[23:8]);
					tag_vld_d = 1'b1;
					body_st_d = 1'b1;
				end
				{3'd2, 3'd0}: begin
					tag_d     = 32'(w[15:8]);
					tag_vld_d = 1'b1;
					body_st_d = 1'b1;
				end
				{3'd0, 3'd3}: begin // Value between '=' and SOH
					body_d     = 32'(w[23:8]);
					body_vld_d = 1'b1;
				end
				{3'd1, 3'd3}: begin
					body_d     = 32'(w[23:16]);
					body_vld_d = 1'b1;
				end
				{3'd0, 3'd2}: begin
					body_d     = 32'(w[15:8]);
					body_vld_d = 1'b1;
				end
				default: ; // Unsupported pair
			endcase
		end else if (soh != FIX_POS_NONE) begin
			// Value ends here, a new tag follows
			case (soh)
				3'd0: begin
					body_d     = 32'(w[31:8]);
					body_vld_d = 1'b1;
					tag_st_d   = 1'b1;
				end
				3'd1: begin
					body_d     = 32'(w[31:16]);
					body_vld_d = 1'b1;
					tag_d      = 32'(w[7:0]);
					tag_vld_d  = 1'b1;
					tag_st_d   = 1'b1;
				end
				3'd2: begin
					body_d     = 32'(w[31:24]);
					body_vld_d = 1'b1;
					tag_d      = 32'(w[15:0]);
					tag_vld_d  = 1'b1;
					tag_st_d   = 1'b1;
				end
				3'd3: begin
					tag_d     = 32'(w[23:0]);
					tag_vld_d = 1'b1;
					tag_st_d  = 1'b1;
				end
				default: ;
			endcase
		end else if (sep != FIX_POS_NONE) begin
			// Tag ends here, a value follows
			case (sep)
				3'd0: begin
					tag_d     = 32'(w[31:8]);
					tag_vld_d = 1'b1;
					body_st_d = 1'b1;
				end
				3'd1: begin
					tag_d      = 32'(w[31:16]);
					tag_vld_d  = 1'b1;
					body_d     = 32'(w[7:0]);
					body_vld_d = 1'b1;
					body_st_d  = 1'b1;
				end
				3'd2: begin
					tag_d      = 32'(w[31:24]);
					tag_vld_d  = 1'b1;
					body_d     = 32'(w[15:0]);
					body_vld_d = 1'b1;
					body_st_d  = 1'b1;
				end
				3'd3: begin
					body_d     = 32'(w[23:0]);
					body_vld_d = 1'b1;
					body_st_d  = 1'b1;
				end
				default: ;
			endcase
		end else if (tag_status_o) begin // Tag spans this word
			tag_d     = w;
			tag_vld_d = 1'b1;
			tag_st_d  = 1'b1;
		end else if (body_status_o) begin // Value spans this word
			body_d     = w;
			body_vld_d = 1'b1;
			body_st_d  = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			tag_valid_o   <= 1'b0;
			body_valid_o  <= 1'b0;
			tag_status_o  <= 1'b0;
			body_status_o <= 1'b0;
		end else begin
			tag_valid_o  <= pop_o && tag_vld_d;
			body_valid_o <= pop_o && body_vld_d;
			if (pop_o) begin
				tag_status_o  <= tag_st_d; // Fed back for the next word
				body_status_o <= body_st_d;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop_o) begin
			tag_o  <= tag_d;
			body_o <= body_d;
		end
	end

	a_quiet_after_stall: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		$past(stall_i) |-> !tag_valid_o && !body_valid_o
	);

endmodule : fix_field_extractor

`default_nettype wire

// ==== source/fix_parser_top.sv ====
// FIX field splitter top with detector, word buffer and extractor

`timescale 1ns/1ps
`default_nettype none

module fix_parser_top (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic [31:0] word_i,
	input  logic        word_valid_i,
	input  logic        stall_i,
	output logic [31:0] tag_o,
	output logic        tag_valid_o,
	output logic [31:0] body_o,
	output logic        body_valid_o,
	output logic        tag_status_o,
	output logic        body_status_o,
	output logic        overflow_o
);

	fix_word_if det_if ();
	fix_word_if buf_if ();

	logic pop; // Extractor consumes the buffer head

	fix_delim_detector u_delim_detector (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.word_i       (word_i),
		.word_valid_i (word_valid_i),
		.out          (det_if.src)
	);

	fix_word_fifo u_word_fifo (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.in         (det_if.dst),
		.out        (buf_if.src),
		.pop_i      (pop),
		.overflow_o (overflow_o)
	);

	fix_field_extractor u_field_extractor (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.in            (buf_if.dst),
		.stall_i       (stall_i),
		.pop_o         (pop),
		.tag_o         (tag_o),
		.body_o        (body_o),
		.tag_valid_o   (tag_valid_o),
		.body_valid_o  (body_valid_o),
		.tag_status_o  (tag_status_o),
		.body_status_o (body_status_o)
	);

endmodule : fix_parser_top

`default_nettype wire

// ==== testbench/fix_parser_tb.sv ====
// Testbench for the FIX field splitter with file-driven words, fragment monitor and timeout

`timescale 1ns/1ps
`default_nettype none

module fix_parser_tb;
	import fix_parser_cfg_pkg::*;

	localparam int unsigned CLK_PERIOD   = 40;
	localparam int unsigned RESET_CYCLES = 10;
	localparam int unsigned STIM_WORDS   = 512;
	localparam int unsigned MAX_GAP      = 3;
	localparam int unsigned DRAIN_CYCLES = FIFO_DEPTH + 3; // Empty buffer plus pipeline
	localparam string       STIM_FILE    = "testbench/fix_stimulus.txt";

	logic        clk;
	logic        arst_n_i;
	logic [31:0] word_i;
	logic        word_valid_i;
	logic        stall_i;
	logic [31:0] tag_o;
	logic        tag_valid_o;
	logic [31:0] body_o;
	logic        body_valid_o;
	logic        tag_status_o;
	logic        body_status_o;
	logic        overflow_o;

	logic [31:0] stim_mem [STIM_WORDS];
	logic [31:0] w_word_q [$];
	int unsigned w_stall_q [$];
	logic [67:0] exp_q [$]; // {tag_valid, tag, body_valid, body, tag_status, body_status}

	int unsigned stall_left;
	int unsigned cycle_count;
	int unsigned timeout_limit;
	int unsigned value_errors;
	int unsigned other_errors;
	logic        stim_loaded;
	logic        stall_prev = 1'b0;

	fix_parser_top u_fix_parser_top (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.word_i        (word_i),
		.word_valid_i  (word_valid_i),
		.stall_i       (stall_i),
		.tag_o         (tag_o),
		.tag_valid_o   (tag_valid_o),
		.body_o        (body_o),
		.body_valid_o  (body_valid_o),
		.tag_status_o  (tag_status_o),
		.body_status_o (body_status_o),
		.overflow_o    (overflow_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic load_stimulus();
		int unsigned idx;
		int unsigned stall_sum;
		logic        done;
		for (int i = 0; i < STIM_WORDS; i++) begin
			stim_mem[i] = {16'hFFFF, 16'(i)}; // Unset entries read as unknown records
		end
		$readmemh(STIM_FILE, stim_mem);
		idx       = 0;
		stall_sum = 0;
		done      = 1'b0;
		while (!done && idx + 7 < STIM_WORDS) begin
			case (stim_mem[idx])
				32'd0: done = 1'b1; // End of list
				32'd1: begin
					w_word_q.push_back(stim_mem[idx + 1]);
					w_stall_q.push_back(stim_mem[idx + 2]);
					stall_sum += stim_mem[idx + 2];
					idx += 3;
				end
				32'd2: begin
					exp_q.push_back({stim_mem[idx + 1][0], stim_mem[idx + 2],
						stim_mem[idx + 3][0], stim_mem[idx + 4],
						stim_mem[idx + 5][0], stim_mem[idx + 6][0]});
					idx += 7;
				end
				default: begin
					other_errors++;
					$display("Stimulus file has unknown record type %h at entry %0d",
						stim_mem[idx], idx);
					done = 1'b1;
				end
			endcase
		end
		if (w_word_q.size() == 0 || exp_q.size() == 0) begin
			other_errors++;
			$display("Stimulus file holds no input words or no expected records");
		end
		timeout_limit = 5 * (w_word_q.size() + stall_sum + w_word_q.size() * MAX_GAP) + 100;
	endtask

	// One clock of input drive with stall_i following the running window
	task automatic step_cycle(input logic valid, input logic [31:0] word);
		@(negedge clk);
		word_valid_i = valid;
		word_i       = word;
		if (stall_left > 0) begin
			stall_i = 1'b1;
			stall_left--;
		end else begin
			stall_i = 1'b0;
		end
	endtask

	task automatic drain_pipeline();
		while (stall_left > 0) begin
			step_cycle(1'b0, '0);
		end
		repeat (DRAIN_CYCLES) step_cycle(1'b0, '0);
	endtask

	// A stalled word starts from an empty buffer and words inside a stall go back to back
	task automatic drive_word(input logic [31:0] word, input int unsigned stall);
		int unsigned gap;
		if (stall > 0) begin
			drain_pipeline();
			step_cycle(1'b1, word);
			stall_left = stall;
		end else begin
			if (stall_left == 0) begin
				gap = $urandom % (MAX_GAP + 1);
				repeat (gap) step_cycle(1'b0, '0);
			end
			step_cycle(1'b1, word);
		end
	endtask

	task automatic verify_reset_outputs();
		if (tag_valid_o !== 1'b0) begin
			value_errors++;
			$display("** Error at %0t ns: tag_valid_o expected 0, got %b", $time, tag_valid_o);
		end
		if (body_valid_o !== 1'b0) begin
			value_errors++;
			$display("** Error at %0t ns: body_valid_o expected 0, got %b", $time, body_valid_o);
		end
		if (tag_status_o !== 1'b0) begin
			value_errors++;
			$display("** Error at %0t ns: tag_status_o expected 0, got %b", $time, tag_status_o);
		end
		if (body_status_o !== 1'b0) begin
			value_errors++;
			$display("** Error at %0t ns: body_status_o expected 0, got %b", $time,
				body_status_o);
		end
		if (overflow_o !== 1'b0) begin
			value_errors++;
			$display("** Error at %0t ns: overflow_o expected 0, got %b", $time, overflow_o);
		end
	endtask

	task automatic compare_fragment();
		logic [67:0] exp_rec;
		logic        exp_tv;
		logic [31:0] exp_tag;
		logic        exp_bv;
		logic [31:0] exp_body;
		logic        exp_ts;
		logic        exp_bs;
		if (stall_prev) begin
			other_errors++;
			$display("At %0t ns a fragment came out of an edge where stall_i was high", $time);
		end
		if (exp_q.size() == 0) begin
			other_errors++;
			$display("At %0t ns a fragment came out but no expected record is left", $time);
			return;
		end
		exp_rec  = exp_q.pop_front();
		exp_tv   = exp_rec[67];
		exp_tag  = exp_rec[66:35];
		exp_bv   = exp_rec[34];
		exp_body = exp_rec[33:2];
		exp_ts   = exp_rec[1];
		exp_bs   = exp_rec[0];
		if (tag_valid_o !== exp_tv) begin
			value_errors++;
			$display("** Error at %0t ns: tag_valid_o expected %b, got %b", $time, exp_tv,
				tag_valid_o);
		end
		if (exp_tv && tag_o !== exp_tag) begin
			value_errors++;
			$display("** Error at %0t ns: tag_o expected %h, got %h", $time, exp_tag, tag_o);
		end
		if (body_valid_o !== exp_bv) begin
			value_errors++;
			$display("** Error at %0t ns: body_valid_o expected %b, got %b", $time, exp_bv,
				body_valid_o);
		end
		if (exp_bv && body_o !== exp_body) begin
			value_errors++;
			$display("** Error at %0t ns: body_o expected %h, got %h", $time, exp_body, body_o);
		end
		if (tag_status_o !== exp_ts) begin
			value_errors++;
			$display("** Error at %0t ns: tag_status_o expected %b, got %b", $time, exp_ts,
				tag_status_o);
		end
		if (body_status_o !== exp_bs) begin
			value_errors++;
			$display("** Error at %0t ns: body_status_o expected %b, got %b", $time, exp_bs,
				body_status_o);
		end
	endtask

	always @(posedge clk) begin
		stall_prev <= stall_i; // Stall seen by the edge that made the outputs
	end

	// Outputs settle after the rising edge
	always @(negedge clk) begin
		if (arst_n_i === 1'b1 && (tag_valid_o === 1'b1 || body_valid_o === 1'b1)) begin
			compare_fragment();
		end
	end

	initial begin
		arst_n_i     = 1'b0;
		word_i       = '0;
		word_valid_i = 1'b0;
		stall_i      = 1'b0;
		stall_left   = 0;
		value_errors = 0;
		other_errors = 0;
		stim_loaded  = 1'b0;
		void'($urandom(32'h7a1942ac));
		load_stimulus();
		stim_loaded = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n_i = 1'b1;
		@(negedge clk);
		verify_reset_outputs();
		for (int i = 0; i < w_word_q.size(); i++) begin
			drive_word(w_word_q[i], w_stall_q[i]);
		end
		drain_pipeline();
		repeat (2) @(posedge clk);
		if (exp_q.size() != 0) begin
			other_errors++;
			$display("%0d expected records were never matched by a fragment", exp_q.size());
		end
		if (overflow_o !== 1'b1) begin
			value_errors++;
			$display("** Error at %0t ns: overflow_o expected 1, got %b", $time, overflow_o);
		end
		$display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		wait (stim_loaded === 1'b1);
		while (cycle_count < timeout_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the run did not reach its end", cycle_count);
		$display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
		$display("tests failed");
		$finish;
	end

endmodule : fix_parser_tb

`default_nettype wire

// ==== testbench/fix_stimulus.txt ====
// W records are 1 then the word and the stall cycles in hex
// E records are 2 then tag_valid tag body_valid body tag_status body_status
// Single delimiter words
1 383D4649 0   2 1 00000038 1 00004649 0 1
1 582E3401 0   2 0 00000000 1 00582E34 1 0
1 3D313233 0   2 0 00000000 1 00313233 0 1
1 01333530 0   2 1 00333530 0 00000000 1 0
1 3931393D 0   2 1 00393139 0 00000000 0 1
1 41420135 0   2 1 00000035 1 00004142 1 0
1 32343D46 0   2 1 00003234 1 00000046 0 1
1 58013334 0   2 1 00003334 1 00000058 1 0
// Multi word tag and value, then two delimiter words
1 35363738 0   2 1 35363738 0 00000000 1 0
1 30313233 0   2 1 30313233 0 00000000 1 0
1 3939393D 0   2 1 00393939 0 00000000 0 1
1 41424344 0   2 0 00000000 1 41424344 0 1
1 45464748 0   2 0 00000000 1 45464748 0 1
1 313D3701 0   2 0 00000000 1 00000037 0 0
1 5A5A5A5A 0
1 01353D42 0   2 1 00000035 0 00000000 0 1
1 3D390134 0   2 0 00000000 1 00000039 0 0
1 0134383D 0   2 1 00003438 0 00000000 0 1
1 3D414201 0   2 0 00000000 1 00004142 0 0
1 4301353D 0   2 1 00000035 0 00000000 0 1
// Unsupported pair clears status so the next plain word is silent
1 013D4142 0
1 44444444 0
// Stall with four buffered words
1 333D5859 6   2 1 00000033 1 00005859 0 1
1 50515253 0   2 0 00000000 1 50515253 0 1
1 54555657 0   2 0 00000000 1 54555657 0 1
1 58595A01 0   2 0 00000000 1 0058595A 1 0
// Long stall and six words, the last two are dropped
1 61626364 1E  2 1 61626364 0 00000000 1 0
1 6566673D 0   2 1 00656667 0 00000000 0 1
1 68696A6B 0   2 0 00000000 1 68696A6B 0 1
1 6C6D016E 0   2 1 0000006E 1 00006C6D 1 0
1 6F707172 0
1 73747576 0
0

// ==== sim.f ====
source/fix_proto_pkg.sv
source/fix_parser_cfg_pkg.sv
source/fix_word_if.sv
source/fix_delim_detector.sv
source/fix_word_fifo.sv
source/fix_field_extractor.sv
source/fix_parser_top.sv
testbench/fix_parser_tb.sv

// ==== Bender.yml ====
package:
  name: fix_parser

sources:
  # Packages first, then the interface and the RTL
  - files:
      - source/fix_proto_pkg.sv
      - source/fix_parser_cfg_pkg.sv
      - source/fix_word_if.sv
      - source/fix_delim_detector.sv
      - source/fix_word_fifo.sv
      - source/fix_field_extractor.sv
      - source/fix_parser_top.sv
  - target: test
    files:
      - testbench/fix_parser_tb.sv
